/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_hdmi_tx
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) hdmi_config.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* filelist.f */
+incdir+.
hdmi_pkg.sv
video_lane_if.sv
video_source.sv
tmds_encoder.sv
tmds_serializer.sv
hdmi_tx_display.sv
tb_hdmi_asserts.sv
tb_hdmi_tx.sv

/* hdmi_config.svh */
// frame geometry and link constants for the TMDS transmitter
// geometry is tiny on purpose so a full frame simulates quickly
// h_active should be a multiple of 8 for even colour bars
`ifndef HDMI_CONFIG_SVH
`define HDMI_CONFIG_SVH

// ---------------------------------------------------------------------------
// horizontal timing in pixels, line total 80
// ---------------------------------------------------------------------------
`define H_ACTIVE 64
`define H_FRONT  4
`define H_SYNC   6
`define H_BACK   6

// ---------------------------------------------------------------------------
// vertical timing in lines, frame total 11
// ---------------------------------------------------------------------------
`define V_ACTIVE 6
`define V_FRONT  1
`define V_SYNC   2
`define V_BACK   2

// 1 means hs and vs are high inside the sync interval
`define SYNC_ACTIVE_HIGH 1

// clock lane word
// bit 0 leaves first so five ones then five zeros on the wire
`define TMDS_CLOCK_SYMBOL 10'b00000_11111

`endif

/* hdmi_pkg.sv */
// shared types and TMDS constants for the transmitter
// lane order is fixed as 0 blue, 1 green, 2 red
`default_nettype none

package hdmi_pkg;

	// three TMDS data lanes
	localparam int NUM_LANES = 3;

	// ------------------------------------------------------------------------
	// pixel types
	// ------------------------------------------------------------------------

	// 24 bit colour with red in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// same word seen as colours or as per-lane bytes
	// lane[0] overlays b and lane[2] overlays r
	typedef union packed {
		rgb_t                        rgb;
		logic [NUM_LANES-1:0][7:0]   lane;
	} pixel_u;

	// ------------------------------------------------------------------------
	// DVI control words indexed by {c1,c0}
	// ------------------------------------------------------------------------
	// written msb first as in the DVI table
	localparam logic [9:0] CTL_SYMBOL_00 = 10'b1101010100;
	localparam logic [9:0] CTL_SYMBOL_01 = 10'b0010101011;
	localparam logic [9:0] CTL_SYMBOL_10 = 10'b0101010100;
	localparam logic [9:0] CTL_SYMBOL_11 = 10'b1010101011;

endpackage

`default_nettype wire

/* hdmi_tx_display.sv */
// TMDS transmitter top, colour bars out on three data lanes
// both clocks and reset come from outside, no PLL here
// outputs are single ended bits, no differential buffers
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_config.svh"

module hdmi_tx_display (
	input  logic clk_pixel,
	input  logic clk_serial,
	input  logic reset,
	output logic hdmi_clk,
	output logic hdmi_d0,
	output logic hdmi_d1,
	output logic hdmi_d2
);

	import hdmi_pkg::*;

	// one lane bundle per TMDS data channel
	video_lane_if lanes [NUM_LANES] ();

	// encoded words toward the serializer
	wire [NUM_LANES-1:0][9:0] symbols;

	// ------------------------------------------------------------------------
	// timing and pattern source
	// ------------------------------------------------------------------------
	video_source #(
		.h_active (`H_ACTIVE),
		.h_front  (`H_FRONT),
		.h_sync   (`H_SYNC),
		.h_back   (`H_BACK),
		.v_active (`V_ACTIVE),
		.v_front  (`V_FRONT),
		.v_sync   (`V_SYNC),
		.v_back   (`V_BACK)
	) video_source_inst (
		.clk_pixel (clk_pixel),
		.reset     (reset),
		.lanes     (lanes)
	);

	// ------------------------------------------------------------------------
	// one encoder per lane
	// ------------------------------------------------------------------------
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_enc
		tmds_encoder tmds_encoder_inst (
			.clk_pixel (clk_pixel),
			.reset     (reset),
			.lane      (lanes[i]),
			.symbol    (symbols[i])
		);
	end

	// ------------------------------------------------------------------------
	// serial clock domain
	// ------------------------------------------------------------------------
	tmds_serializer tmds_serializer_inst (
		.clk_serial (clk_serial),
		.reset      (reset),
		.symbols    (symbols),
		.hdmi_clk   (hdmi_clk),
		.hdmi_d0    (hdmi_d0),
		.hdmi_d1    (hdmi_d1),
		.hdmi_d2    (hdmi_d2)
	);

endmodule

`default_nettype wire

/* tb_hdmi_asserts.sv */
// concurrent checks bound into each encoder lane and the serializer
// failures also bump a counter in the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_asserts #(
	parameter bit is_encoder = 1'b1
) (
	input logic       clk,
	input logic       reset,
	input logic       de_in,
	input logic [9:0] symbol,
	input logic [3:0] phase,
	input logic       clk_out
);

	import hdmi_pkg::*;

	if (is_encoder) begin : g_enc_checks
		// blanking at the lane input leaves as a control word two clocks later
		a_blank_ctl: assert property (@(posedge clk) disable iff (reset)
			!$past(de_in, 2) |-> (symbol == CTL_SYMBOL_00) || (symbol == CTL_SYMBOL_01) ||
				(symbol == CTL_SYMBOL_10) || (symbol == CTL_SYMBOL_11))
		else begin
			$error("encoder symbol is not a control word during blanking");
			tb_hdmi_tx.assert_fails = tb_hdmi_tx.assert_fails + 1;
		end
	end else begin : g_ser_checks
		// ten states per word
		a_phase_range: assert property (@(posedge clk) disable iff (reset)
			phase <= 4'd9)
		else begin
			$error("serializer phase counter above 9");
			tb_hdmi_tx.assert_fails = tb_hdmi_tx.assert_fails + 1;
		end

		a_clk_idle: assert property (@(posedge clk) reset |=> !clk_out)
		else begin
			$error("clock lane high while reset is held");
			tb_hdmi_tx.assert_fails = tb_hdmi_tx.assert_fails + 1;
		end
	end

endmodule

`default_nettype wire

/* tb_hdmi_tx.sv */
// directed testbench for the TMDS transmitter top level
// rebuilds 10 bit words from the serial lanes and checks three frames
// expects clk_serial at exactly 10x clk_pixel with rising edges aligned
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_config.svh"

module tb_hdmi_tx;

	import hdmi_pkg::*;

	localparam int h_total     = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int frame_words = h_total * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
	// three frames, reset and slack for the pipeline fill
	localparam int cycle_limit = 3 * frame_words + 4 + 100;
	localparam logic sync_on   = (`SYNC_ACTIVE_HIGH != 0);
	localparam int hs_first    = `H_ACTIVE + `H_FRONT;
	localparam int vs_first    = `V_ACTIVE + `V_FRONT;

	logic clk_pixel  = 1'b0;
	logic clk_serial = 1'b1;
	logic reset;
	logic hdmi_clk;
	logic hdmi_d0;
	logic hdmi_d1;
	logic hdmi_d2;

	// words as {clk, d2, d1, d0}
	logic [3:0][9:0] word_q [$];
	logic [3:0][9:0] rx_sr;
	logic [3:0][9:0] cur;
	logic            aligned = 1'b0;
	int              low_run = 0;
	int              bit_idx = 0;
	// frame position of cur
	int              x = 0;
	int              y = 0;
	logic            framed = 1'b0;
	logic            vs_prev = 1'b0;
	logic            vs_seen = 1'b0;
	int              since_vs = 0;
	int              vs_gap = 0;
	int              cycles = 0;
	int              assert_fails = 0;

	always #5 clk_pixel = ~clk_pixel;
	// starts high so rising edges land on every pixel edge
	always #0.5 clk_serial = ~clk_serial;

	hdmi_tx_display hdmi_tx_display_inst (
		.clk_pixel  (clk_pixel),
		.clk_serial (clk_serial),
		.reset      (reset),
		.hdmi_clk   (hdmi_clk),
		.hdmi_d0    (hdmi_d0),
		.hdmi_d1    (hdmi_d1),
		.hdmi_d2    (hdmi_d2)
	);

	// encoder checks watch the lane de ahead of both register stages
	bind tmds_encoder tb_hdmi_asserts #(.is_encoder(1'b1)) enc_asserts (
		.clk(clk_pixel), .reset(reset), .de_in(lane.de), .symbol(symbol),
		.phase(4'd0), .clk_out(1'b0)
	);
	bind tmds_serializer tb_hdmi_asserts #(.is_encoder(1'b0)) ser_asserts (
		.clk(clk_serial), .reset(reset), .de_in(1'b1), .symbol(10'd0),
		.phase(phase), .clk_out(hdmi_clk)
	);

	// ------------------------------------------------------------------------
	// reporting
	// ------------------------------------------------------------------------
	task automatic stop_with_failure();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_eq(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH at %0t: %s expected 'h%0h actual 'h%0h",
				$time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	always @(posedge clk_pixel) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d pixel clocks, three frames never arrived", cycles);
			stop_with_failure();
		end
	end

	// ------------------------------------------------------------------------
	// deserializer, word boundary is the first clock lane one after 5 lows
	// ------------------------------------------------------------------------
	always @(negedge clk_serial) begin
		if (reset) begin
			aligned = 1'b0;
			low_run = 0;
		end else if (!aligned) begin
			if (hdmi_clk && low_run >= 5) begin
				aligned = 1'b1;
				bit_idx = 0;
			end
			low_run = hdmi_clk ? 0 : low_run + 1;
		end
		if (aligned) begin
			rx_sr[0][bit_idx] = hdmi_d0;
			rx_sr[1][bit_idx] = hdmi_d1;
			rx_sr[2][bit_idx] = hdmi_d2;
			rx_sr[3][bit_idx] = hdmi_clk;
			bit_idx = (bit_idx == 9) ? 0 : bit_idx + 1;
			if (bit_idx == 0)
				word_q.push_back(rx_sr);
		end
	end

	// ------------------------------------------------------------------------
	// TMDS decode by the DVI receiver rule
	// ------------------------------------------------------------------------
	function automatic logic [7:0] tmds_decode(input logic [9:0] sym);
		logic [7:0] q;
		logic [7:0] d;
		// bit 9 undoes the inversion
		q = sym[9] ? ~sym[7:0] : sym[7:0];
		d[0] = q[0];
		// bit 8 high means xor chaining
		for (int i = 1; i < 8; i++)
			d[i] = sym[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
		return d;
	endfunction

	// {c1,c0} of a control word, -1 for a data word
	function automatic int ctl_index(input logic [9:0] sym);
		case (sym)
			CTL_SYMBOL_00: return 0;
			CTL_SYMBOL_01: return 1;
			CTL_SYMBOL_10: return 2;
			CTL_SYMBOL_11: return 3;
			default:       return -1;
		endcase
	endfunction

	// pops one word, steps x and y and tracks vsync starts on lane 0
	task automatic next_word();
		int   c;
		logic vs_now;
		while (word_q.size() == 0)
			@(posedge clk_pixel);
		cur = word_q.pop_front();
		// every aligned clock word is the fixed pattern
		check_eq("hdmi_clk word", `TMDS_CLOCK_SYMBOL, cur[3]);
		if (framed) begin
			x = (x == h_total - 1) ? 0 : x + 1;
			if (x == 0)
				y = (y * h_total + h_total == frame_words) ? 0 : y + 1;
		end
		c = ctl_index(cur[0]);
		vs_now = (c >= 0) && (c[1] == sync_on);
		since_vs++;
		if (vs_now && !vs_prev) begin
			vs_gap = vs_seen ? since_vs : 0;
			vs_seen = 1'b1;
			since_vs = 0;
		end
		vs_prev = vs_now;
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset_idle();
		for (int i = 0; i < 3; i++) begin
			@(negedge clk_pixel);
			check_eq("{hdmi_clk,d2,d1,d0} in reset", 4'b0000,
				{hdmi_clk, hdmi_d2, hdmi_d1, hdmi_d0});
		end
		@(posedge clk_pixel);
		reset <= 1'b0;
	endtask

	// skip blanking until the first active word, which is x 0 line 0
	task automatic align_to_frame();
		do
			next_word();
		while (ctl_index(cur[0]) >= 0);
		framed = 1'b1;
	endtask

	task automatic test_clock_and_sync();
		logic hs_exp;
		logic vs_exp;
		for (int n = 0; n < frame_words; n++) begin
			hs_exp = (x >= hs_first && x < hs_first + `H_SYNC) ? sync_on : !sync_on;
			vs_exp = (y >= vs_first && y < vs_first + `V_SYNC) ? sync_on : !sync_on;
			if (x >= `H_ACTIVE || y >= `V_ACTIVE) begin
				check_eq("hdmi_d0 {vs,hs}", {vs_exp, hs_exp}, ctl_index(cur[0]));
				check_eq("hdmi_d1 blanking word", CTL_SYMBOL_00, cur[1]);
				check_eq("hdmi_d2 blanking word", CTL_SYMBOL_00, cur[2]);
			end
			next_word();
		end
	endtask

	task automatic test_colour_bars();
		pixel_u p;
		int     bar;
		for (int n = 0; n < frame_words; n++) begin
			if (x < `H_ACTIVE && y < `V_ACTIVE) begin
				bar = x / (`H_ACTIVE / 8);
				p.rgb.r = bar[2] ? 8'hff : 8'h00;
				p.rgb.g = bar[1] ? 8'hff : 8'h00;
				p.rgb.b = bar[0] ? 8'hff : 8'h00;
				for (int i = 0; i < NUM_LANES; i++)
					check_eq($sformatf("hdmi_d%0d byte x=%0d y=%0d", i, x, y),
						p.lane[i], tmds_decode(cur[i]));
			end
			next_word();
		end
	endtask

	task automatic test_geometry_and_balance();
		int   data_words;
		int   active_lines;
		int   run [NUM_LANES];
		logic vs_checked;
		data_words = 0;
		active_lines = 0;
		vs_checked = 1'b0;
		run = '{0, 0, 0};
		for (int n = 0; n < frame_words; n++) begin
			if (vs_gap != 0) begin
				check_eq("words between vsync starts", 880, vs_gap);
				vs_gap = 0;
				vs_checked = 1'b1;
			end
			if (ctl_index(cur[0]) < 0)
				data_words++;
			// ones minus zeros over each active run
			for (int i = 0; i < NUM_LANES; i++) begin
				run[i] = (ctl_index(cur[i]) < 0) ? run[i] + 2 * $countones(cur[i]) - 10 : 0;
				check_eq($sformatf("hdmi_d%0d disparity within 10", i), 1,
					(run[i] <= 10) && (run[i] >= -10));
			end
			if (x == h_total - 1) begin
				check_eq($sformatf("data words on line %0d", y),
					(y < `V_ACTIVE) ? `H_ACTIVE : 0, data_words);
				if (data_words > 0)
					active_lines++;
				data_words = 0;
			end
			next_word();
		end
		check_eq("active lines in frame", `V_ACTIVE, active_lines);
		check_eq("vsync start seen after a full frame", 1, vs_checked);
	endtask

	initial begin
		reset = 1'b1;
		test_reset_idle();
		align_to_frame();
		test_clock_and_sync();
		test_colour_bars();
		test_geometry_and_balance();
		if (assert_fails == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("%0d bound assertions failed during the run", assert_fails);
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

/* tmds_encoder.sv */
// DVI TMDS 8b/10b encoder for one lane, two register stages
// symbol appears two pixel clocks after the lane input
// blanking emits control words only, no guard bands or data islands
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
	input  logic          clk_pixel,
	input  logic          reset,
	video_lane_if.encoder lane,
	output logic [9:0]    symbol
);

	import hdmi_pkg::*;

	// stage 1 combinational
	logic [3:0]        n1_d;
	logic              use_xnor;
	logic [8:0]        q_m_d;
	// stage 1 registers
	logic [8:0]        q_m;
	logic              de_q;
	logic [1:0]        ctl_q;
	// stage 2 combinational
	logic [3:0]        n1_q;
	logic [3:0]        n0_q;
	logic signed [5:0] bal;
	logic [9:0]        sym_next;
	logic signed [5:0] cnt_next;
	// running disparity, ones minus zeros sent so far
	logic signed [5:0] cnt;

	// ------------------------------------------------------------------------
	// stage 1, transition minimisation
	// ------------------------------------------------------------------------
	always_comb begin
		n1_d = '0;
		for (int i = 0; i < 8; i++) begin
			n1_d = n1_d + 4'(lane.data[i]);
		end
		// xnor chain when the byte is ones heavy
		use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !lane.data[0]);
		q_m_d[0] = lane.data[0];
		for (int i = 1; i < 8; i++) begin
			q_m_d[i] = use_xnor ? ~(q_m_d[i-1] ^ lane.data[i]) : (q_m_d[i-1] ^ lane.data[i]);
		end
		// bit 8 set means xor was used
		q_m_d[8] = ~use_xnor;
	end

	always_ff @(posedge clk_pixel) begin
		if (reset) begin
			de_q  <= 1'b0;
			ctl_q <= 2'b00;
		end else begin
			de_q  <= lane.de;
			ctl_q <= lane.ctl;
		end
	end

	always_ff @(posedge clk_pixel) begin
		q_m <= q_m_d;
	end

	// ------------------------------------------------------------------------
	// stage 2, dc balance by conditional inversion
	// ------------------------------------------------------------------------
	always_comb begin
		n1_q = '0;
		for (int i = 0; i < 8; i++) begin
			n1_q = n1_q + 4'(q_m[i]);
		end
		n0_q = 4'd8 - n1_q;
		bal  = $signed({2'b00, n1_q}) - $signed({2'b00, n0_q});
		if ((cnt == 6'sd0) || (n1_q == n0_q)) begin
			// neutral case, bit 9 mirrors bit 8
			sym_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
			cnt_next = q_m[8] ? cnt + bal : cnt - bal;
		end else if (((cnt > 6'sd0) && (n1_q > n0_q)) ||
			((cnt < 6'sd0) && (n0_q > n1_q))) begin
			// same sign as the disparity so invert
			sym_next = {1'b1, q_m[8], ~q_m[7:0]};
			cnt_next = cnt + (q_m[8] ? 6'sd2 : 6'sd0) - bal;
		end else begin
			sym_next = {1'b0, q_m[8], q_m[7:0]};
			cnt_next = cnt - (q_m[8] ? 6'sd0 : 6'sd2) + bal;
		end
	end

	always_ff @(posedge clk_pixel) begin
		if (reset) begin
			symbol <= CTL_SYMBOL_00;
			cnt    <= '0;
		end else if (!de_q) begin
			// blanking restarts the disparity count
			cnt <= '0;
			case (ctl_q)
				2'b00:   symbol <= CTL_SYMBOL_00;
				2'b01:   symbol <= CTL_SYMBOL_01;
				2'b10:   symbol <= CTL_SYMBOL_10;
				default: symbol <= CTL_SYMBOL_11;
			endcase
		end else begin
			symbol <= sym_next;
			cnt    <= cnt_next;
		end
	end

endmodule

`default_nettype wire

/* tmds_serializer.sv */
// 10:1 serializer for three data lanes and the clock lane
// clk_serial must be 10x clk_pixel, phase aligned, with reset
// released on a shared edge so the word boundary lands on pixel edges
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_config.svh"

module tmds_serializer (
	input  logic                                 clk_serial,
	input  logic                                 reset,
	input  logic [hdmi_pkg::NUM_LANES-1:0][9:0]  symbols,
	output logic                                 hdmi_clk,
	output logic                                 hdmi_d0,
	output logic                                 hdmi_d1,
	output logic                                 hdmi_d2
);

	import hdmi_pkg::*;

	// bit position inside the current word
	logic [3:0]                 phase;
	logic [NUM_LANES-1:0][9:0]  data_shift;
	logic [9:0]                 clk_shift;

	// ------------------------------------------------------------------------
	// word phase and shift registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_serial) begin
		if (reset) begin
			phase      <= '0;
			data_shift <= '0;
			clk_shift  <= '0;
		end else if (phase == 4'd9) begin
			// wrap edge coincides with a pixel edge
			phase      <= '0;
			data_shift <= symbols;
			// clock lane reloads in the same word frame
			clk_shift  <= `TMDS_CLOCK_SYMBOL;
		end else begin
			phase <= phase + 4'd1;
			// lsb first
			for (int i = 0; i < NUM_LANES; i++) begin
				data_shift[i] <= {1'b0, data_shift[i][9:1]};
			end
			clk_shift <= {1'b0, clk_shift[9:1]};
		end
	end

	// ------------------------------------------------------------------------
	// single ended lane outputs
	// ------------------------------------------------------------------------
	assign hdmi_clk = clk_shift[0];
	// d0 blue and syncs
	assign hdmi_d0  = data_shift[0][0];
	// d1 green
	assign hdmi_d1  = data_shift[1][0];
	// d2 red
	assign hdmi_d2  = data_shift[2][0];

endmodule

`default_nettype wire

/* video_lane_if.sv */
// one TMDS lane worth of video from the source to an encoder
// no handshake, every pixel clock carries one slot
// data only meaningful while de is high
`timescale 1ns/1ps
`default_nettype none

interface video_lane_if;

	// display enable for the active area
	logic       de;
	// control pair, {vs,hs} on lane 0 and zero elsewhere
	logic [1:0] ctl;
	// colour byte for this lane
	logic [7:0] data;

	// timing generator side
	modport source (
		output de,
		output ctl,
		output data
	);

	// 8b/10b encoder side
	modport encoder (
		input de,
		input ctl,
		input data
	);

endinterface

`default_nettype wire

/* video_source.sv */
// video timing and colour bar generator in the pixel clock domain
// active area sits at the start of each line and frame
// bar width is h_active/8, leftover pixels wrap the bar index
`timescale 1ns/1ps
`default_nettype none

`include "hdmi_config.svh"

module video_source #(
	parameter int h_active = `H_ACTIVE,
	parameter int h_front  = `H_FRONT,
	parameter int h_sync   = `H_SYNC,
	parameter int h_back   = `H_BACK,
	parameter int v_active = `V_ACTIVE,
	parameter int v_front  = `V_FRONT,
	parameter int v_sync   = `V_SYNC,
	parameter int v_back   = `V_BACK
) (
	input  logic         clk_pixel,
	input  logic         reset,
	video_lane_if.source lanes [hdmi_pkg::NUM_LANES]
);

	import hdmi_pkg::*;

	localparam int h_total = h_active + h_front + h_sync + h_back;
	localparam int v_total = v_active + v_front + v_sync + v_back;
	localparam int hw      = $clog2(h_total);
	localparam int vw      = $clog2(v_total);
	// guard against a zero divisor on very narrow lines
	localparam int bar_w   = (h_active >= 8) ? h_active / 8 : 1;
	localparam logic sync_on = (`SYNC_ACTIVE_HIGH != 0);

	logic [hw-1:0] h_cnt;
	logic [vw-1:0] v_cnt;
	logic          de_next;
	logic          hs_next;
	logic          vs_next;
	logic [2:0]    bar;
	pixel_u        pix;

	// ------------------------------------------------------------------------
	// pixel and line counters
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_pixel) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_cnt == hw'(h_total - 1)) begin
			h_cnt <= '0;
			// end of line so step the line count
			v_cnt <= (v_cnt == vw'(v_total - 1)) ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// timing decode and bar pattern for the current count
	// ------------------------------------------------------------------------
	always_comb begin
		de_next = (h_cnt < h_active) && (v_cnt < v_active);
		// sync intervals follow the front porch
		hs_next = ((h_cnt >= h_active + h_front) &&
			(h_cnt < h_active + h_front + h_sync)) ? sync_on : ~sync_on;
		vs_next = ((v_cnt >= v_active + v_front) &&
			(v_cnt < v_active + v_front + v_sync)) ? sync_on : ~sync_on;
		bar = 3'(h_cnt / bar_w);
		// each index bit switches one primary fully on
		pix.rgb.r = bar[2] ? 8'hff : 8'h00;
		pix.rgb.g = bar[1] ? 8'hff : 8'h00;
		pix.rgb.b = bar[0] ? 8'hff : 8'h00;
	end

	// ------------------------------------------------------------------------
	// lane registers, one cycle behind the counters
	// ------------------------------------------------------------------------
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		always_ff @(posedge clk_pixel) begin
			if (reset) begin
				lanes[i].de  <= 1'b0;
				// syncs idle at their inactive level
				lanes[i].ctl <= (i == 0) ? {~sync_on, ~sync_on} : 2'b00;
			end else begin
				lanes[i].de  <= de_next;
				// only lane 0 carries the syncs
				lanes[i].ctl <= (i == 0) ? {vs_next, hs_next} : 2'b00;
			end
		end

		// lane byte picked out of the union
		always_ff @(posedge clk_pixel) begin
			lanes[i].data <= pix.lane[i];
		end
	end

endmodule

`default_nettype wire
